// ==== source/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// cache geometry
// four ways of 16 sets, 64-byte lines
`define DC_WAYS 4
`define DC_SETS 16

// a line is 8 memory beats of 64 bits
`define DC_BEATS 8

// each line is kept as 4 rows of 128 bits
`define DC_ROWS 4

// everything from here up bypasses the cache
`define DC_UNCACHED_BASE 32'h9000_0000

`endif

// ==== source/dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

	// requester and memory data word, with its byte strobe
	typedef logic [63:0] word_t;
	typedef logic [7:0]  strb_t;

	// one store row and its byte enables
	typedef logic [127:0] row_t;
	typedef logic [15:0]  row_strb_t;

	// address split: tag 31:10, set 9:6, row 5:4, half 3
	typedef logic [21:0] tag_t;
	typedef logic [3:0]  index_t;
	typedef logic [1:0]  row_addr_t;

	// one bit per way
	typedef logic [`DC_WAYS-1:0] way_mask_t;

	typedef enum logic [2:0] {
		st_idle,
		st_refill,
		st_unc_read,
		st_wr_data,
		st_wr_resp
	} ctrl_state_t;

endpackage

// ==== source/dcache_way.sv ====
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_way
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  index_t    index,
	input  tag_t      tag,
	input  row_addr_t row_addr,
	input  logic      sel,
	input  logic      fill,
	input  row_strb_t row_wen,
	input  row_t      row_wdata,
	output logic      hit,
	output row_t      row_rdata
);

	// tag store and valid bits, one entry per set
	tag_t                tags [`DC_SETS];
	logic [`DC_SETS-1:0] valid_bits;

	// data store, rows of a line sit next to each other
	row_t rows [`DC_SETS*`DC_ROWS];

	logic [$bits(index_t)+$bits(row_addr_t)-1:0] row_idx;

	assign row_idx = {index, row_addr};

	// lookup is combinational on the current set
	assign hit = valid_bits[index] && (tags[index] == tag);

	// byte-writable row store
	// read data lags the address by one cycle
	always_ff @(posedge clk) begin
		if (sel) begin
			for (int b = 0; b < $bits(row_strb_t); b++) begin
				if (row_wen[b]) begin
					rows[row_idx][8*b +: 8] <= row_wdata[8*b +: 8];
				end
			end
		end
		// old contents come out on a same-cycle write
		row_rdata <= rows[row_idx];
	end

	// tag is written on the last refill beat
	always_ff @(posedge clk) begin
		if (sel && fill) begin
			tags[index] <= tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
		end else if (sel && fill) begin
			valid_bits[index] <= 1'b1;
		end
	end

endmodule

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        valid,
	input  logic        wren,
	input  logic [31:0] addr,
	input  word_t       wdata,
	input  strb_t       strb,
	input  way_mask_t   way_hit,
	input  logic        ar_ready,
	input  word_t       r_data,
	input  logic        r_valid,
	input  logic        r_last,
	input  logic        aw_ready,
	input  logic        w_ready,
	input  logic        b_valid,
	output logic        ready,
	output logic [31:0] ar_addr,
	output logic [7:0]  ar_len,
	output logic        ar_valid,
	output logic [31:0] aw_addr,
	output logic        aw_valid,
	output word_t       w_data,
	output strb_t       w_strb,
	output logic        w_valid,
	output way_mask_t   way_sel,
	output logic        fill,
	output row_addr_t   row_addr,
	output row_strb_t   row_wen,
	output row_t        row_wdata,
	output way_mask_t   resp_way,
	output word_t       unc_word
);

	localparam int BEAT_W = $clog2(`DC_BEATS);
	localparam int PTR_W  = $clog2(`DC_WAYS);

	ctrl_state_t      state;
	logic [BEAT_W-1:0] beat_cnt;
	logic [PTR_W-1:0]  rr_ptr;
	logic              cached;
	logic              req;
	logic              any_hit;
	logic              rd_hit;
	way_mask_t         victim;

	assign cached = addr < `DC_UNCACHED_BASE;
	// nothing is taken while ready is up
	assign req     = valid && !ready && (state == st_idle);
	assign any_hit = cached && (way_hit != '0);
	assign rd_hit  = req && !wren && any_hit;
	// round-robin victim, stable for the whole refill
	assign victim  = way_mask_t'(1) << rr_ptr;

	always_comb begin
		// read miss or uncached read, address held until taken
		ar_valid = req && !wren && !any_hit;
		ar_addr  = cached ? {addr[31:6], 6'b0} : {addr[31:3], 3'b0};
		ar_len   = cached ? 8'(`DC_BEATS - 1) : 8'd0;
		// every write goes through to memory
		aw_valid = req && wren;
		aw_addr  = addr;
		w_valid  = (state == st_wr_data);
		w_data   = wdata;
		w_strb   = strb;
		way_sel   = '0;
		fill      = 1'b0;
		row_addr  = addr[5:4];
		row_wen   = '0;
		row_wdata = {wdata, wdata};
		case (state)
			st_idle: begin
				// write hit updates the row when the address is taken
				if (aw_valid && aw_ready && any_hit) begin
					way_sel = way_hit;
					row_wen = addr[3] ? {strb, 8'h00} : {8'h00, strb};
				end
			end
			st_refill: begin
				// even beats fill the low half, odd beats the high half
				row_addr  = beat_cnt[BEAT_W-1:1];
				row_wdata = {r_data, r_data};
				if (r_valid) begin
					way_sel = victim;
					row_wen = beat_cnt[0] ? 16'hff00 : 16'h00ff;
					fill    = r_last;
				end
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= st_idle;
			ready    <= 1'b0;
			resp_way <= '0;
			beat_cnt <= '0;
			rr_ptr   <= '0;
		end else begin
			// ready is a single-cycle pulse
			ready    <= 1'b0;
			resp_way <= '0;
			case (state)
				st_idle: begin
					beat_cnt <= '0;
					if (rd_hit) begin
						ready    <= 1'b1;
						resp_way <= way_hit;
					end else if (ar_valid && ar_ready) begin
						state <= cached ? st_refill : st_unc_read;
					end else if (aw_valid && aw_ready) begin
						state <= st_wr_data;
					end
				end
				st_refill: begin
					if (r_valid) begin
						beat_cnt <= beat_cnt + 1'b1;
						// line complete, the retried lookup will hit
						if (r_last) begin
							rr_ptr <= rr_ptr + 1'b1;
							state  <= st_idle;
						end
					end
				end
				st_unc_read: begin
					if (r_valid) begin
						ready <= 1'b1;
						state <= st_idle;
					end
				end
				st_wr_data: begin
					if (w_ready) begin
						state <= st_wr_resp;
					end
				end
				st_wr_resp: begin
					if (b_valid) begin
						ready <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// the single uncached beat, held for the read selector
	always_ff @(posedge clk) begin
		if ((state == st_unc_read) && r_valid) begin
			unc_word <= r_data;
		end
	end

endmodule

// ==== source/dcache_read_sel.sv ====
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_read_sel
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  row_t      row_rdata [`DC_WAYS],
	input  way_mask_t resp_way,
	input  word_t     unc_word,
	input  logic      half,
	output word_t     rdata
);

	logic half_q;
	row_t sel_row;

	// half select follows the row read by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			half_q <= 1'b0;
		end else begin
			half_q <= half;
		end
	end

	// mask is one-hot on a hit, so an or over the ways picks the row
	always_comb begin
		sel_row = '0;
		for (int w = 0; w < `DC_WAYS; w++) begin
			if (resp_way[w]) begin
				sel_row = sel_row | row_rdata[w];
			end
		end
	end

	// empty mask means the word came straight from memory
	assign rdata = (resp_way == '0) ? unc_word :
		(half_q ? sel_row[127:64] : sel_row[63:0]);

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ns
`include "dcache_macros.svh"

module dcache_top
	import dcache_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	// requester side
	input  logic        valid,
	input  logic        wren,
	input  logic [31:0] addr,
	input  word_t       wdata,
	input  strb_t       strb,
	output logic        ready,
	output word_t       rdata,
	// memory read channels
	output logic [31:0] ar_addr,
	output logic [7:0]  ar_len,
	output logic        ar_valid,
	input  logic        ar_ready,
	input  word_t       r_data,
	input  logic        r_valid,
	input  logic        r_last,
	// memory write channels
	output logic [31:0] aw_addr,
	output logic        aw_valid,
	input  logic        aw_ready,
	output word_t       w_data,
	output strb_t       w_strb,
	output logic        w_valid,
	input  logic        w_ready,
	input  logic        b_valid
);

	index_t    index;
	tag_t      tag;
	way_mask_t way_hit;
	way_mask_t way_sel;
	way_mask_t resp_way;
	logic      fill;
	row_addr_t row_addr;
	row_strb_t row_wen;
	row_t      row_wdata;
	row_t      row_rdata [`DC_WAYS];
	word_t     unc_word;

	assign index = addr[9:6];
	assign tag   = addr[31:10];

	dcache_ctrl ctrl_i (
		.*
	);

	// identical ways, the shared row fields go to all of them
	for (genvar g = 0; g < `DC_WAYS; g++) begin : gen_way
		dcache_way way_i (
			.clk       (clk),
			.rst       (rst),
			.index     (index),
			.tag       (tag),
			.row_addr  (row_addr),
			.sel       (way_sel[g]),
			.fill      (fill),
			.row_wen   (row_wen),
			.row_wdata (row_wdata),
			.hit       (way_hit[g]),
			.row_rdata (row_rdata[g])
		);
	end

	// address bit 3 picks the half of the row
	dcache_read_sel read_sel_i (
		.half (addr[3]),
		.*
	);

endmodule

// ==== test/tb_mem_model.sv ====
`timescale 1ns/1ns

module tb_mem_model
	import dcache_pkg::*;
#(
	parameter int SEED = 12359
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] ar_addr,
	input  logic [7:0]  ar_len,
	input  logic        ar_valid,
	output logic        ar_ready,
	output word_t       r_data,
	output logic        r_valid,
	output logic        r_last,
	input  logic [31:0] aw_addr,
	input  logic        aw_valid,
	output logic        aw_ready,
	input  word_t       w_data,
	input  strb_t       w_strb,
	input  logic        w_valid,
	output logic        w_ready,
	output logic        b_valid,
	input  logic [31:0] peek_addr,
	output word_t       peek_data,
	output int          bursts
);

	// only written words live here, the rest follow the fill rule
	word_t mem [logic [31:0]];

	logic [31:0] lcg;
	logic [31:0] rd_addr;
	logic [7:0]  rd_left;
	logic        rd_busy;
	logic [31:0] wr_addr;
	logic        wr_busy;

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		return x * 32'd1103515245 + 32'd12345;
	endfunction

	// address in the upper half, its complement in the lower half
	function automatic word_t load(input logic [31:0] a);
		logic [31:0] wa;
		wa = {a[31:3], 3'b000};
		if (mem.exists(wa)) begin
			return mem[wa];
		end
		return {wa, ~wa};
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t d, input strb_t s);
		word_t m;
		m = old;
		for (int b = 0; b < 8; b++) begin
			if (s[b]) begin
				m[8*b +: 8] = d[8*b +: 8];
			end
		end
		return m;
	endfunction

	// read channel, beats follow the address back to back
	always_ff @(posedge clk) begin
		if (rst) begin
			lcg      <= 32'(SEED);
			ar_ready <= 1'b0;
			r_valid  <= 1'b0;
			r_last   <= 1'b0;
			r_data   <= '0;
			rd_busy  <= 1'b0;
			rd_addr  <= '0;
			rd_left  <= '0;
			bursts   <= 0;
		end else begin
			lcg     <= next_rand(lcg);
			r_valid <= 1'b0;
			r_last  <= 1'b0;
			if (rd_busy) begin
				r_valid <= 1'b1;
				r_data  <= load(rd_addr);
				r_last  <= (rd_left == 8'd0);
				rd_addr <= rd_addr + 32'd8;
				rd_left <= rd_left - 8'd1;
				rd_busy <= (rd_left != 8'd0);
			end else if (ar_valid && ar_ready) begin
				ar_ready <= 1'b0;
				rd_busy  <= 1'b1;
				rd_addr  <= ar_addr;
				rd_left  <= ar_len;
				// full line bursts only
				if (ar_len == 8'd7) begin
					bursts <= bursts + 1;
				end
			end else begin
				// random stall
				ar_ready <= lcg[16];
			end
		end
	end

	// write channel, address first, then data, then the response
	always_ff @(posedge clk) begin
		if (rst) begin
			aw_ready <= 1'b0;
			w_ready  <= 1'b0;
			b_valid  <= 1'b0;
			wr_busy  <= 1'b0;
			wr_addr  <= '0;
		end else begin
			b_valid <= 1'b0;
			if (wr_busy) begin
				aw_ready <= 1'b0;
				if (w_valid && w_ready) begin
					w_ready <= 1'b0;
					wr_busy <= 1'b0;
					b_valid <= 1'b1;
				end else begin
					w_ready <= lcg[20];
				end
			end else if (aw_valid && aw_ready) begin
				aw_ready <= 1'b0;
				wr_busy  <= 1'b1;
				wr_addr  <= aw_addr;
			end else begin
				aw_ready <= lcg[24];
			end
		end
	end

	// strobed update on the data handshake
	always @(posedge clk) begin
		if (!rst && wr_busy && w_valid && w_ready) begin
			mem[{wr_addr[31:3], 3'b000}] = merge_bytes(load(wr_addr), w_data, w_strb);
		end
	end

	// back door view of the array, one cycle behind the address
	always_ff @(posedge clk) begin
		peek_data <= load(peek_addr);
	end

endmodule

// ==== test/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache
	import dcache_pkg::*;
#(
	parameter int SEED = 12359
);

	localparam int CLK_HALF     = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 5;
	localparam int TIMEOUT      = 200;

	logic        clk;
	logic        rst;
	logic        valid;
	logic        wren;
	logic [31:0] addr;
	word_t       wdata;
	strb_t       strb;
	logic        ready;
	word_t       rdata;
	logic [31:0] ar_addr;
	logic [7:0]  ar_len;
	logic        ar_valid;
	logic        ar_ready;
	word_t       r_data;
	logic        r_valid;
	logic        r_last;
	logic [31:0] aw_addr;
	logic        aw_valid;
	logic        aw_ready;
	word_t       w_data;
	strb_t       w_strb;
	logic        w_valid;
	logic        w_ready;
	logic        b_valid;
	logic [31:0] peek_addr;
	word_t       peek_data;
	int          bursts;

	dcache_top dut_i (
		.*
	);

	tb_mem_model #(
		.SEED (SEED)
	) mem_i (
		.*
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "bit mismatch");
		end
	endtask

	// sampled mid-cycle, away from the clock edge
	task automatic wait_ready(input logic [31:0] a);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (ready !== 1'b1 && cycles < TIMEOUT);
		if (ready !== 1'b1) begin
			$display("cache gave no ready within %0d cycles for address %h", TIMEOUT, a);
			$display(">>> FAIL");
			$fatal(1, "ready timeout");
		end
	endtask

	task automatic run_request(input logic is_write, input logic [31:0] a, input word_t wd,
			input strb_t st, input word_t ew, input int ec);
		@(posedge clk);
		#DRIVE_DELAY;
		valid = 1'b1;
		wren  = is_write;
		addr  = a;
		wdata = wd;
		strb  = st;
		wait_ready(a);
		if (!is_write) begin
			check_word("rdata", rdata, ew);
		end
		check_count("refills", bursts, ec);
		// drop the request in the cycle after ready
		@(posedge clk);
		#DRIVE_DELAY;
		valid = 1'b0;
		wren  = 1'b0;
		@(negedge clk);
		// ready is a single pulse
		check_bit("ready", ready, 1'b0);
	endtask

	task automatic check_memory(input logic [31:0] a, input word_t ew);
		@(posedge clk);
		#DRIVE_DELAY;
		peek_addr = a;
		@(posedge clk);
		@(negedge clk);
		check_word("memory", peek_data, ew);
	endtask

	initial begin
		int          fd;
		int          n;
		int          reqs;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		word_t       wd;
		strb_t       st;
		word_t       ew;
		int          ec;
		reqs      = 0;
		rst       = 1'b1;
		valid     = 1'b0;
		wren      = 1'b0;
		addr      = '0;
		wdata     = '0;
		strb      = '0;
		peek_addr = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		// the cache stays quiet until asked
		repeat (4) begin
			@(negedge clk);
			check_bit("ready", ready, 1'b0);
			check_bit("ar_valid", ar_valid, 1'b0);
			check_bit("aw_valid", aw_valid, 1'b0);
			check_bit("w_valid", w_valid, 1'b0);
		end
		fd = $fopen("test/dcache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file test/dcache_stimulus.txt");
			$display(">>> FAIL");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			// blank and comment lines
			if (n == 0 || line.len() < 2 || line.getc(0) == 8'h23) begin
				continue;
			end
			n = $sscanf(line, "%c %h %h %h %h %d", op, a, wd, st, ew, ec);
			if (n != 6) begin
				$display("stimulus line could not be read: %s", line);
				$display(">>> FAIL");
				$fatal(1, "bad stimulus");
			end
			case (op)
				"R": run_request(1'b0, a, wd, st, ew, ec);
				"W": run_request(1'b1, a, wd, st, ew, ec);
				"M": begin
					check_memory(a, ew);
					check_count("refills", bursts, ec);
				end
				default: begin
					$display("stimulus line has an unknown operation: %s", line);
					$display(">>> FAIL");
					$fatal(1, "bad operation");
				end
			endcase
			reqs++;
		end
		$fclose(fd);
		if (reqs == 0) begin
			$display("stimulus file held no requests");
			$display(">>> FAIL");
			$fatal(1, "empty stimulus");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== all.f ====
+incdir+source
source/dcache_pkg.sv
source/dcache_way.sv
source/dcache_ctrl.sv
source/dcache_read_sel.sv
source/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

TOP       ?= tb_dcache
SEED      ?= 12359
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir/$(TOP)_$(SEED)

FILE_LIST := all.f
SOURCES   := $(wildcard source/*.sv source/*.svh test/*.sv)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary -Wno-fatal --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/dcache_stimulus.txt ====
# op addr wdata strb expected_word refills, all hex except refills
# R read and compare, W write, M compare the memory model word; refills is the running burst count
R 00001000 0000000000000000 00 00001000ffffefff 1
R 00001008 0000000000000000 00 00001008ffffeff7 1
R 00001010 0000000000000000 00 00001010ffffefef 1
R 00001018 0000000000000000 00 00001018ffffefe7 1
R 00001020 0000000000000000 00 00001020ffffefdf 1
R 00001028 0000000000000000 00 00001028ffffefd7 1
R 00001030 0000000000000000 00 00001030ffffefcf 1
R 00001038 0000000000000000 00 00001038ffffefc7 1
R 00001010 0000000000000000 00 00001010ffffefef 1
W 00001008 1122334455667788 3c 0000000000000000 1
R 00001008 0000000000000000 00 000033445566eff7 1
M 00001008 0000000000000000 00 000033445566eff7 1
R 00001000 0000000000000000 00 00001000ffffefff 1
W 00002050 a1b2c3d4e5f60718 ff 0000000000000000 1
R 00002050 0000000000000000 00 a1b2c3d4e5f60718 2
R 00002058 0000000000000000 00 00002058ffffdfa7 2
R 00004080 0000000000000000 00 00004080ffffbf7f 3
R 00004480 0000000000000000 00 00004480ffffbb7f 4
R 00004880 0000000000000000 00 00004880ffffb77f 5
R 00004c80 0000000000000000 00 00004c80ffffb37f 6
R 00005080 0000000000000000 00 00005080ffffaf7f 7
R 00004080 0000000000000000 00 00004080ffffbf7f 8
R 000050b8 0000000000000000 00 000050b8ffffaf47 8
R 90000040 0000000000000000 00 900000406fffffbf 8
R 90000040 0000000000000000 00 900000406fffffbf 8
W 90000040 0123456789abcdef ff 0000000000000000 8
R 90000040 0000000000000000 00 0123456789abcdef 8
M 90000040 0000000000000000 00 0123456789abcdef 8
